/* source/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width
`define WORD_SIZE 16

// Architectural registers, 2-bit index
`define NUM_REGS 4

// Direct-mapped BTB lines, indexed by low PC bits
`define BTB_ENTRIES 16

// Unified memory size in words
`define MEM_DEPTH 256

`endif

/* source/cpu_pkg.sv */
`include "cpu_consts.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	// All ALU, jump-register, WWD and HLT forms share the R-type opcode
	typedef enum logic [3:0] {
		OP_BNE   = 4'd0,
		OP_BEQ   = 4'd1,
		OP_BGZ   = 4'd2,
		OP_BLZ   = 4'd3,
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_JMP   = 4'd9,
		OP_JAL   = 4'd10,
		OP_RTYPE = 4'd15
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'd0,
		FN_SUB = 6'd1,
		FN_AND = 6'd2,
		FN_ORR = 6'd3,
		FN_NOT = 6'd4,
		FN_TCP = 6'd5,
		FN_SHL = 6'd6,
		FN_SHR = 6'd7,
		FN_JPR = 6'd25,
		FN_JRL = 6'd26,
		FN_WWD = 6'd28,
		FN_HLT = 6'd29
	} func_e;

	// Encoded to match the low three function bits
	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOT, ALU_TCP, ALU_SHL, ALU_SHR
	} alu_op_e;

	typedef enum logic [1:0] {SRC_REG, SRC_IMM, SRC_ONE, SRC_EIGHT} src_e;
	typedef enum logic [1:0] {DEST_RD, DEST_RT, DEST_LINK} dest_e;
	typedef enum logic [1:0] {FWD_NONE, FWD_WB, FWD_MEM} fwd_e;

	typedef struct packed {
		alu_op_e alu_op;
		src_e    alu_src;
		dest_e   reg_dest;
		logic    imm_zero;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    mem_to_reg;
		logic    pc_to_reg;
		logic    branch;
		logic    jtype_jump;
		logic    rtype_jump;
		logic    is_wwd;
		logic    is_halt;
	} ctrl_t;

	typedef struct packed {
		logic  valid;
		word_t instr;
		word_t pc_plus1;
		logic  pred_taken;
		word_t pred_pc;
	} if_id_t;

	typedef struct packed {
		logic     valid;
		ctrl_t    ctrl;
		opcode_e  opcode;
		word_t    pc_plus1;
		word_t    read1;
		word_t    read2;
		word_t    imm;
		word_t    jump_target;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic     pred_taken;
		word_t    pred_pc;
	} id_ex_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc_plus1;
		word_t    alu_result;
		word_t    store_data;
		reg_idx_t dest;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t    ctrl;
		word_t    pc_plus1;
		word_t    alu_result;
		word_t    read_data;
		reg_idx_t dest;
	} mem_wb_t;

endpackage

/* source/alu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu import cpu_pkg::*; (
	input  word_t   a,
	input  word_t   b,
	input  alu_op_e op,
	output word_t   result
);

	logic [$clog2(`WORD_SIZE)-1:0] shamt;

	// Shift amount is 1 for SHL/SHR and 8 for LHI
	assign shamt = b[$clog2(`WORD_SIZE)-1:0];

	always_comb begin
		case (op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_NOT: result = ~a;
			ALU_TCP: result = ~a + 1'b1;
			ALU_SHL: result = a << shamt;
			ALU_SHR: result = a >> shamt;
			default: result = '0;
		endcase
	end

endmodule

/* source/register_file.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file import cpu_pkg::*; (
	input  logic     Clk,
	input  reg_idx_t read1,
	input  reg_idx_t read2,
	input  reg_idx_t write_reg,
	input  word_t    write_data,
	input  logic     reg_write,
	output word_t    read_out1,
	output word_t    read_out2
);

	word_t regs [`NUM_REGS];

	always_ff @(posedge Clk) begin
		if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

	// Write-back in the same cycle is visible to decode
	assign read_out1 = (reg_write && write_reg == read1) ? write_data : regs[read1];
	assign read_out2 = (reg_write && write_reg == read2) ? write_data : regs[read2];

endmodule

/* source/control.sv */
`timescale 1ns/1ps

module control import cpu_pkg::*; (
	input  word_t instruction,
	input  logic  flush,
	output ctrl_t ctrl
);

	opcode_e opcode;
	func_e   funct;

	assign opcode = opcode_e'(instruction[15:12]);
	assign funct = func_e'(instruction[5:0]);

	always_comb begin
		ctrl = '0;
		if (!flush) begin
			case (opcode)
				OP_ADI, OP_ORI, OP_LHI, OP_LWD: begin
					ctrl.reg_dest = DEST_RT;
					ctrl.reg_write = 1'b1;
					ctrl.alu_src = (opcode == OP_LHI) ? SRC_EIGHT : SRC_IMM;
					ctrl.alu_op = (opcode == OP_ORI) ? ALU_OR :
						(opcode == OP_LHI) ? ALU_SHL : ALU_ADD;
					ctrl.imm_zero = (opcode == OP_ORI);
					ctrl.mem_read = (opcode == OP_LWD);
					ctrl.mem_to_reg = (opcode == OP_LWD);
				end
				OP_SWD: begin
					ctrl.alu_src = SRC_IMM;
					ctrl.mem_write = 1'b1;
				end
				OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ: ctrl.branch = 1'b1;
				OP_JMP: ctrl.jtype_jump = 1'b1;
				OP_JAL: begin
					ctrl.jtype_jump = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.pc_to_reg = 1'b1;
					ctrl.reg_dest = DEST_LINK;
				end
				OP_RTYPE: begin
					case (funct)
						FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_NOT, FN_TCP, FN_SHL, FN_SHR: begin
							ctrl.alu_op = alu_op_e'(instruction[2:0]);
							ctrl.reg_write = 1'b1;
							if (funct == FN_SHL || funct == FN_SHR) begin
								ctrl.alu_src = SRC_ONE;
							end
						end
						FN_JPR: ctrl.rtype_jump = 1'b1;
						FN_JRL: begin
							ctrl.rtype_jump = 1'b1;
							ctrl.reg_write = 1'b1;
							ctrl.pc_to_reg = 1'b1;
							ctrl.reg_dest = DEST_LINK;
						end
						FN_WWD: ctrl.is_wwd = 1'b1;
						FN_HLT: ctrl.is_halt = 1'b1;
						default: ctrl = '0;
					endcase
				end
				default: ctrl = '0;
			endcase
		end
	end

endmodule

/* source/forwarding_unit.sv */
`timescale 1ns/1ps

module forwarding_unit import cpu_pkg::*; (
	input  reg_idx_t id_ex_rs,
	input  reg_idx_t id_ex_rt,
	input  reg_idx_t ex_mem_dest,
	input  reg_idx_t mem_wb_dest,
	input  logic     ex_mem_reg_write,
	input  logic     mem_wb_reg_write,
	output fwd_e     forward_a,
	output fwd_e     forward_b
);

	// Younger result in the memory stage wins
	function automatic fwd_e pick(input reg_idx_t src);
		if (ex_mem_reg_write && ex_mem_dest == src)
			return FWD_MEM;
		else if (mem_wb_reg_write && mem_wb_dest == src)
			return FWD_WB;
		return FWD_NONE;
	endfunction

	always_comb begin
		forward_a = pick(id_ex_rs);
		forward_b = pick(id_ex_rt);
	end

endmodule

/* source/btb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module btb import cpu_pkg::*; (
	input  logic  Clk,
	input  logic  reset,
	input  word_t if_pc,
	output word_t pred_pc,
	output logic  pred_taken,
	input  word_t ex_pc,
	input  logic  update,
	input  logic  taken,
	input  word_t target
);

	localparam int IDX_W = $clog2(`BTB_ENTRIES);

	logic [`BTB_ENTRIES-1:0] valid;
	logic [`BTB_ENTRIES-1:0] taken_bit;
	logic [`WORD_SIZE-1:IDX_W] tags [`BTB_ENTRIES];
	word_t targets [`BTB_ENTRIES];

	logic [IDX_W-1:0] if_idx;
	logic [IDX_W-1:0] ex_idx;
	logic hit;

	assign if_idx = if_pc[IDX_W-1:0];
	assign ex_idx = ex_pc[IDX_W-1:0];
	assign hit = valid[if_idx] && tags[if_idx] == if_pc[`WORD_SIZE-1:IDX_W];

	assign pred_taken = hit && taken_bit[if_idx];
	assign pred_pc = pred_taken ? targets[if_idx] : if_pc + 1'b1;

	always_ff @(posedge Clk) begin
		if (reset) begin
			valid <= '0;
		end else if (update) begin
			valid[ex_idx] <= 1'b1;
		end
	end

	// Taken bit tracks the last resolved outcome
	always_ff @(posedge Clk) begin
		if (update) begin
			tags[ex_idx] <= ex_pc[`WORD_SIZE-1:IDX_W];
			targets[ex_idx] <= target;
			taken_bit[ex_idx] <= taken;
		end
	end

endmodule

/* source/cpu.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu import cpu_pkg::*; (
	input  logic  Clk,
	input  logic  reset,
	output logic  read_inst,
	output word_t inst_addr,
	input  word_t inst_data,
	output logic  data_read,
	output logic  data_write,
	output word_t data_addr,
	output word_t write_data,
	input  word_t read_data,
	output word_t num_inst,
	output word_t output_port,
	output logic  output_valid,
	output logic  is_halted
);

	word_t pc;
	logic fetching;
	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	mem_wb_t mem_wb;

	word_t pred_pc;
	logic pred_taken;
	ctrl_t ctrl;
	reg_idx_t if_rs;
	reg_idx_t if_rt;
	word_t read_out1;
	word_t read_out2;
	word_t imm;
	logic stall;
	logic kill;
	logic flush;

	fwd_e forward_a;
	fwd_e forward_b;
	word_t wb_data;
	word_t mem_fwd;
	word_t op_a;
	word_t op_b;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t ex_pc;
	word_t target;
	word_t next_pc;
	reg_idx_t ex_dest;
	logic cond;
	logic taken;
	logic mispredict;
	logic halt_ex;

	assign read_inst = fetching;
	assign inst_addr = pc;

	// Decode
	assign if_rs = if_id.instr[11:10];
	assign if_rt = if_id.instr[9:8];
	assign imm = ctrl.imm_zero ? {{(`WORD_SIZE-8){1'b0}}, if_id.instr[7:0]} :
		{{(`WORD_SIZE-8){if_id.instr[7]}}, if_id.instr[7:0]};

	// Load followed by a consumer waits one cycle
	assign stall = id_ex.ctrl.mem_read && if_id.valid && (ex_dest == if_rs || ex_dest == if_rt);
	assign kill = mispredict || halt_ex || is_halted;
	assign flush = !if_id.valid || stall || kill;

	control i_control (.instruction(if_id.instr), .flush(flush), .ctrl(ctrl));

	register_file i_register_file (
		.Clk(Clk),
		.read1(if_rs),
		.read2(if_rt),
		.write_reg(mem_wb.dest),
		.write_data(wb_data),
		.reg_write(mem_wb.ctrl.reg_write),
		.read_out1(read_out1),
		.read_out2(read_out2)
	);

	// Execute
	forwarding_unit i_forwarding_unit (
		.id_ex_rs(id_ex.rs),
		.id_ex_rt(id_ex.rt),
		.ex_mem_dest(ex_mem.dest),
		.mem_wb_dest(mem_wb.dest),
		.ex_mem_reg_write(ex_mem.ctrl.reg_write),
		.mem_wb_reg_write(mem_wb.ctrl.reg_write),
		.forward_a(forward_a),
		.forward_b(forward_b)
	);

	assign mem_fwd = ex_mem.ctrl.pc_to_reg ? ex_mem.pc_plus1 : ex_mem.alu_result;
	assign wb_data = mem_wb.ctrl.mem_to_reg ? mem_wb.read_data :
		mem_wb.ctrl.pc_to_reg ? mem_wb.pc_plus1 : mem_wb.alu_result;
	assign op_a = (forward_a == FWD_MEM) ? mem_fwd : (forward_a == FWD_WB) ? wb_data : id_ex.read1;
	assign op_b = (forward_b == FWD_MEM) ? mem_fwd : (forward_b == FWD_WB) ? wb_data : id_ex.read2;

	// LHI shifts the immediate itself by 8
	assign alu_a = (id_ex.ctrl.alu_src == SRC_EIGHT) ? id_ex.imm : op_a;

	always_comb begin
		case (id_ex.ctrl.alu_src)
			SRC_IMM:   alu_b = id_ex.imm;
			SRC_ONE:   alu_b = `WORD_SIZE'd1;
			SRC_EIGHT: alu_b = `WORD_SIZE'd8;
			default:   alu_b = op_b;
		endcase
		case (id_ex.ctrl.reg_dest)
			DEST_RT:   ex_dest = id_ex.rt;
			DEST_LINK: ex_dest = reg_idx_t'(2);
			default:   ex_dest = id_ex.rd;
		endcase
		case (id_ex.opcode)
			OP_BNE:  cond = (op_a != op_b);
			OP_BEQ:  cond = (op_a == op_b);
			OP_BGZ:  cond = !op_a[`WORD_SIZE-1] && (op_a != '0);
			OP_BLZ:  cond = op_a[`WORD_SIZE-1];
			default: cond = 1'b0;
		endcase
	end

	alu i_alu (.a(alu_a), .b(alu_b), .op(id_ex.ctrl.alu_op), .result(alu_result));

	assign taken = id_ex.ctrl.jtype_jump || id_ex.ctrl.rtype_jump || (id_ex.ctrl.branch && cond);
	assign target = id_ex.ctrl.jtype_jump ? id_ex.jump_target :
		id_ex.ctrl.rtype_jump ? op_a : id_ex.pc_plus1 + id_ex.imm;
	assign next_pc = taken ? target : id_ex.pc_plus1;
	assign mispredict = id_ex.valid &&
		(taken != id_ex.pred_taken || (taken && target != id_ex.pred_pc));
	assign halt_ex = id_ex.ctrl.is_halt;
	assign ex_pc = id_ex.pc_plus1 - 1'b1;

	btb i_btb (
		.Clk(Clk),
		.reset(reset),
		.if_pc(pc),
		.pred_pc(pred_pc),
		.pred_taken(pred_taken),
		.ex_pc(ex_pc),
		.update(id_ex.ctrl.branch || id_ex.ctrl.jtype_jump || id_ex.ctrl.rtype_jump),
		.taken(taken),
		.target(target)
	);

	assign output_valid = id_ex.ctrl.is_wwd;
	assign output_port = output_valid ? op_a : '0;

	// Memory stage
	assign data_read = ex_mem.ctrl.mem_read;
	assign data_write = ex_mem.ctrl.mem_write;
	assign data_addr = ex_mem.alu_result;
	assign write_data = ex_mem.store_data;

	always_ff @(posedge Clk) begin
		if (reset) begin
			pc <= '0;
			fetching <= 1'b0;
			if_id <= '0;
			id_ex <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
			num_inst <= '0;
			is_halted <= 1'b0;
		end else begin
			if (mispredict)
				pc <= next_pc;
			else if (fetching && !stall && !halt_ex)
				pc <= pred_pc;
			fetching <= !(halt_ex || is_halted);

			if (kill) begin
				if_id.valid <= 1'b0;
			end else if (!stall) begin
				if_id.valid <= fetching;
				if_id.instr <= inst_data;
				if_id.pc_plus1 <= pc + 1'b1;
				if_id.pred_taken <= pred_taken;
				if_id.pred_pc <= pred_pc;
			end

			// Flushed control makes this a bubble
			id_ex.valid <= !flush;
			id_ex.ctrl <= ctrl;
			id_ex.opcode <= opcode_e'(if_id.instr[15:12]);
			id_ex.pc_plus1 <= if_id.pc_plus1;
			id_ex.read1 <= read_out1;
			id_ex.read2 <= read_out2;
			id_ex.imm <= imm;
			id_ex.jump_target <= {if_id.pc_plus1[`WORD_SIZE-1:12], if_id.instr[11:0]};
			id_ex.rs <= if_rs;
			id_ex.rt <= if_rt;
			id_ex.rd <= if_id.instr[7:6];
			id_ex.pred_taken <= if_id.pred_taken;
			id_ex.pred_pc <= if_id.pred_pc;

			ex_mem.ctrl <= id_ex.ctrl;
			ex_mem.pc_plus1 <= id_ex.pc_plus1;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= op_b;
			ex_mem.dest <= ex_dest;

			mem_wb.ctrl <= ex_mem.ctrl;
			mem_wb.pc_plus1 <= ex_mem.pc_plus1;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.read_data <= read_data;
			mem_wb.dest <= ex_mem.dest;

			if (id_ex.valid)
				num_inst <= num_inst + 1'b1;
			if (halt_ex)
				is_halted <= 1'b1;
		end
	end

endmodule

/* source/memory.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module memory import cpu_pkg::*; (
	input  logic  Clk,
	input  logic  read_inst,
	input  word_t inst_addr,
	output word_t inst_data,
	input  logic  data_read,
	input  logic  data_write,
	input  word_t data_addr,
	input  word_t write_data,
	output word_t read_data
);

	localparam int ADDR_W = $clog2(`MEM_DEPTH);

	word_t mem [`MEM_DEPTH];
	logic [ADDR_W-1:0] inst_idx;
	logic [ADDR_W-1:0] data_idx;

	initial begin
		$readmemh("dv/program.hex", mem);
	end

	// Upper address bits wrap onto the array
	assign inst_idx = inst_addr[ADDR_W-1:0];
	assign data_idx = data_addr[ADDR_W-1:0];

	assign inst_data = read_inst ? mem[inst_idx] : '0;
	assign read_data = data_read ? mem[data_idx] : '0;

	always_ff @(posedge Clk) begin
		if (data_write) begin
			mem[data_idx] <= write_data;
		end
	end

endmodule

/* source/cpu_system.sv */
`timescale 1ns/1ps

module cpu_system import cpu_pkg::*; (
	input  logic  Clk,
	input  logic  reset,
	output word_t num_inst,
	output word_t output_port,
	output logic  output_valid,
	output logic  is_halted
);

	logic read_inst;
	logic data_read;
	logic data_write;
	word_t inst_addr;
	word_t inst_data;
	word_t data_addr;
	word_t write_data;
	word_t read_data;

	cpu i_cpu (
		.Clk(Clk),
		.reset(reset),
		.read_inst(read_inst),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.write_data(write_data),
		.read_data(read_data),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

	memory i_memory (
		.Clk(Clk),
		.read_inst(read_inst),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.write_data(write_data),
		.read_data(read_data)
	);

endmodule

/* dv/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties import cpu_pkg::*; (
	input logic  Clk,
	input logic  reset,
	input logic  read_inst,
	input logic  data_read,
	input logic  data_write,
	input word_t num_inst,
	input logic  output_valid,
	input logic  is_halted
);

	int failures = 0;

	// Checked one cycle on, once the reset values have landed
	strobes_low_in_reset: assert property (@(posedge Clk)
		reset |=> !read_inst && !data_read && !data_write)
	else begin
		$error("Memory strobe active during reset");
		failures++;
	end

	halt_is_sticky: assert property (@(posedge Clk) disable iff (reset)
		is_halted |=> is_halted && $stable(num_inst))
	else begin
		$error("Halt state lost or instruction count moved after halt");
		failures++;
	end

	no_output_when_halted: assert property (@(posedge Clk) disable iff (reset)
		is_halted |-> !output_valid)
	else begin
		$error("Output word produced while halted");
		failures++;
	end

	data_strobes_exclusive: assert property (@(posedge Clk) disable iff (reset)
		!(data_read && data_write))
	else begin
		$error("Data read and data write active together");
		failures++;
	end

endmodule

bind cpu_system cpu_properties i_cpu_properties (
	.Clk(Clk),
	.reset(reset),
	.read_inst(read_inst),
	.data_read(data_read),
	.data_write(data_write),
	.num_inst(num_inst),
	.output_valid(output_valid),
	.is_halted(is_halted)
);

/* dv/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int NUM_WORDS = 16;
	// Instructions that reach execute, HLT included
	localparam int EXPECTED_INSTS = 51;
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + 40 * EXPECTED_INSTS;

	// Index one past the last word of each output test
	localparam int ARITH_LAST = 5;
	localparam int LOAD_LAST = 6;
	localparam int BRANCH_LAST = 12;
	localparam int CALL_LAST = 16;

	logic Clk;
	logic reset;
	word_t num_inst;
	word_t output_port;
	logic output_valid;
	logic is_halted;

	int errors = 0;
	int checks = 0;
	int tests_done = 0;
	int test_start_errors = 0;
	int out_idx = 0;
	int cycle_count = 0;
	int total_errors;

	// WWD words in program order
	word_t expected [NUM_WORDS] = '{
		16'h0008, 16'h000E, 16'hFFF1, 16'h0006, 16'h0086,
		16'hFFF1,
		16'h0001, 16'h0002, 16'h0003, 16'h0004, 16'h0004, 16'hFFF1,
		16'h0021, 16'h0014, 16'h0024, 16'h002B
	};

	cpu_system i_dut (
		.Clk(Clk),
		.reset(reset),
		.num_inst(num_inst),
		.output_port(output_port),
		.output_valid(output_valid),
		.is_halted(is_halted)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	task automatic check_value(input string name, input word_t actual, input word_t want);
		checks++;
		assert (actual === want)
		else begin
			$display("CHECK FAILED: %s = %h, expected %h", name, actual, want);
			errors++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("Test %0d %s: %0d errors", num, name, errors - test_start_errors);
		test_start_errors = errors;
		tests_done++;
	endtask

	// Outputs are sampled away from the rising edge
	always @(negedge Clk) begin
		if (!reset && output_valid) begin
			assert (out_idx < NUM_WORDS)
			else begin
				$display("Unexpected output word %h after the expected sequence", output_port);
				errors++;
			end
			if (out_idx < NUM_WORDS) begin
				check_value("output_port", output_port, expected[out_idx]);
				out_idx++;
			end
		end
	end

	always @(posedge Clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d of %0d output words seen",
				cycle_count, out_idx, NUM_WORDS);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge Clk);
		#1;
		reset = 1'b0;

		check_value("read_inst", word_t'(i_dut.read_inst), '0);
		check_value("data_read", word_t'(i_dut.data_read), '0);
		check_value("data_write", word_t'(i_dut.data_write), '0);
		check_value("num_inst", num_inst, '0);
		check_value("output_valid", word_t'(output_valid), '0);
		check_value("is_halted", word_t'(is_halted), '0);
		end_test(1, "reset state");

		wait (out_idx >= ARITH_LAST);
		end_test(2, "arithmetic and forwarding");
		wait (out_idx >= LOAD_LAST);
		end_test(3, "load and store");
		wait (out_idx >= BRANCH_LAST);
		end_test(4, "branches and BTB");
		wait (out_idx >= CALL_LAST);
		end_test(5, "calls and returns");

		wait (is_halted);
		@(negedge Clk);
		check_value("out_idx", word_t'(out_idx), word_t'(NUM_WORDS));
		check_value("num_inst", num_inst, word_t'(EXPECTED_INSTS));
		// Count must hold while frozen
		repeat (4) @(negedge Clk);
		check_value("num_inst", num_inst, word_t'(EXPECTED_INSTS));
		check_value("is_halted", word_t'(is_halted), 16'h0001);
		end_test(6, "halt");

		total_errors = errors + i_dut.i_cpu_properties.failures;
		$display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, total_errors);
		if (total_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* dv/program.hex */
// Columns: instruction word in hex, then word address and assembly
// Registers r0..r3, link register r2
6000 // 00 LHI r0, 0x00
4105 // 01 ADI r1, r0, 5
46FE // 02 ADI r2, r1, -2
F6C0 // 03 ADD r3, r1, r2
FC1C // 04 WWD r3
FD01 // 05 SUB r0, r3, r1
F046 // 06 SHL r1, r0
F783 // 07 ORR r2, r1, r3
F81C // 08 WWD r2
F8C4 // 09 NOT r3, r2
FC1C // 10 WWD r3
FC05 // 11 TCP r0, r3
F047 // 12 SHR r1, r0
F602 // 13 AND r0, r1, r2
F01C // 14 WWD r0
5080 // 15 ORI r0, r0, 0x80
F01C // 16 WWD r0
4972 // 17 ADI r1, r2, 0x72
8700 // 18 SWD r3, 0(r1)
7400 // 19 LWD r0, 0(r1)
F01C // 20 WWD r0
6100 // 21 LHI r1, 0x00
4604 // 22 ADI r2, r1, 4
4501 // 23 ADI r1, r1, 1
F41C // 24 WWD r1
06FD // 25 BNE r1, r2, -3
1401 // 26 BEQ r1, r0, +1
F81C // 27 WWD r2
2001 // 28 BGZ r0, +1
F01C // 29 WWD r0
3001 // 30 BLZ r0, +1
F81C // 31 WWD r2
A028 // 32 JAL 40
F41C // 33 WWD r1
4B0A // 34 ADI r3, r2, 10
FC1A // 35 JRL r3
FC1C // 36 WWD r3
F01D // 37 HLT
F01D // 38 HLT padding
F01D // 39 HLT padding
F81C // 40 WWD r2
4510 // 41 ADI r1, r1, 0x10
F819 // 42 JPR r2
F81C // 43 WWD r2
F819 // 44 JPR r2
F01D // 45 HLT padding
F01D // 46 HLT padding

/* filelist.f */
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/control.sv
source/forwarding_unit.sv
source/btb.sv
source/cpu.sv
source/memory.sv
source/cpu_system.sv
dv/cpu_properties.sv
dv/cpu_tb.sv
